//--- axis_uart.f
+incdir+verilog
verilog/axis_uart_pkg.sv
verilog/axis_uart_rx.sv
verilog/axis_uart_tx.sv
verilog/axis_uart_csr.sv
verilog/axis_uart.sv
test/axis_uart_tb.sv

//--- Bender.yml
package:
  name: axis_uart

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axis_uart_pkg.sv
      - verilog/axis_uart_rx.sv
      - verilog/axis_uart_tx.sv
      - verilog/axis_uart_csr.sv
      - verilog/axis_uart.sv
  - target: test
    files:
      - test/axis_uart_tb.sv

//--- test/axis_uart_tb.sv
`timescale 1ns/1ns

module axis_uart_tb;

    localparam int unsigned TEST_DIVIDER  = 8;
    // longest frame is start, 8 data bits, parity and stop
    localparam int unsigned FRAME_CLKS    = 11 * TEST_DIVIDER;
    // 25 loopback frames, 2 injected, 2 for overrun, plus room for the idle windows and commands
    localparam int unsigned FRAME_COUNT   = 25 + 2 + 2 + 4;
    localparam int unsigned WATCHDOG_CLKS = FRAME_COUNT * FRAME_CLKS * 4;
    localparam int unsigned CMD_TIMEOUT   = 20;
    localparam int unsigned BEAT_TIMEOUT  = 2 * FRAME_CLKS + 20;

    logic                        m_axis;
    logic                        rst_n;
    logic                        cfg_req;
    axis_uart_pkg::csr_req_t     cfg_cmd;
    logic                        cfg_ack;
    axis_uart_pkg::uart_status_t cfg_rdata;
    logic                        uart_rx;
    logic                        uart_tx;
    logic                        rx_valid;
    axis_uart_pkg::axis_beat_t   rx_beat;
    logic                        rx_ready;
    logic                        tx_valid;
    axis_uart_pkg::axis_beat_t   tx_beat;
    logic                        tx_ready;
    logic                        loopback;
    logic                        bang_line;
    logic                        rx_valid_prev;

    int unsigned                 error_count;
    int unsigned                 check_count;
    int unsigned                 beat_count;
    logic [31:0]                 rng_state;
    axis_uart_pkg::uart_status_t last_status;
    axis_uart_pkg::uart_parity_e cur_parity;

    assign uart_rx = loopback ? uart_tx : bang_line;

    axis_uart dut (
        .m_axis      (m_axis),
        .rst_n_i     (rst_n),
        .cfg_req_i   (cfg_req),
        .cfg_cmd_i   (cfg_cmd),
        .cfg_ack_o   (cfg_ack),
        .cfg_rdata_o (cfg_rdata),
        .uart_rx_i   (uart_rx),
        .uart_tx_o   (uart_tx),
        .rx_valid_o  (rx_valid),
        .rx_beat_o   (rx_beat),
        .rx_ready_i  (rx_ready),
        .tx_valid_i  (tx_valid),
        .tx_beat_i   (tx_beat),
        .tx_ready_o  (tx_ready)
    );

    initial begin
        m_axis = 1'b0;
        forever #2 m_axis = ~m_axis;
    end

    // counts every beat the receiver presents, held or not
    always @(negedge m_axis) begin
        if (rst_n && rx_valid && !rx_valid_prev) begin
            beat_count++;
        end
        rx_valid_prev <= rx_valid;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge m_axis);
        $display("timeout: the tests did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // even parity makes the ones in data plus parity even, odd makes them odd
    function automatic logic frame_parity_bit(input logic [7:0] data,
                                              input axis_uart_pkg::uart_parity_e mode);
        if (mode == axis_uart_pkg::PARITY_ODD) begin
            return ~^data;
        end
        return ^data;
    endfunction

    function automatic axis_uart_pkg::uart_status_t status_of(input logic [7:0] cnt,
                                                              input logic fe, input logic ov);
        axis_uart_pkg::uart_status_t s;
        s                = '0;
        s.parity_err_cnt = cnt;
        s.frame_err      = fe;
        s.overrun        = ov;
        return s;
    endfunction

    task automatic report_failure(input string what);
        error_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_beat(input string name, input axis_uart_pkg::axis_beat_t got,
                              input axis_uart_pkg::axis_beat_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input axis_uart_pkg::uart_status_t got,
                                input axis_uart_pkg::uart_status_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic cmd(input axis_uart_pkg::csr_op_e op, input logic [15:0] arg);
        int unsigned n;
        @(negedge m_axis);
        cfg_cmd.op  = op;
        cfg_cmd.arg = arg;
        cfg_req     = 1'b1;
        n = 0;
        while (!cfg_ack && n < CMD_TIMEOUT) begin
            @(negedge m_axis);
            n++;
        end
        if (!cfg_ack) begin
            report_failure("cfg_ack_o never rose for a command");
        end
        last_status = cfg_rdata;
        cfg_req     = 1'b0;
        // ack has to outlive req by the synchronizer delay
        @(negedge m_axis);
        check_bit("cfg_ack_o", cfg_ack, 1'b1);
        n = 0;
        while (cfg_ack && n < CMD_TIMEOUT) begin
            @(negedge m_axis);
            n++;
        end
        if (cfg_ack) begin
            report_failure("cfg_ack_o never fell after req was dropped");
        end
    endtask

    task automatic expect_status(input logic [7:0] cnt, input logic fe, input logic ov);
        cmd(axis_uart_pkg::OP_READ_STATUS, 16'h0000);
        check_status("cfg_rdata_o", last_status, status_of(cnt, fe, ov));
    endtask

    task automatic next_byte(output logic [7:0] b);
        rng_state = xorshift32(rng_state);
        b         = rng_state[7:0];
    endtask

    task automatic send_beat(input logic [7:0] data);
        int unsigned n;
        @(negedge m_axis);
        tx_valid      = 1'b1;
        tx_beat.tdata = data;
        n = 0;
        while (!tx_ready && n < BEAT_TIMEOUT) begin
            @(negedge m_axis);
            n++;
        end
        if (!tx_ready) begin
            report_failure("tx_ready_o stayed low, the beat was not accepted");
        end
        @(negedge m_axis);
        tx_valid = 1'b0;
    endtask

    task automatic wait_tx_idle();
        int unsigned n;
        n = 0;
        while (!tx_ready && n < BEAT_TIMEOUT) begin
            @(negedge m_axis);
            n++;
        end
        check_bit("tx_ready_o", tx_ready, 1'b1);
    endtask

    task automatic expect_beat(input logic [7:0] data);
        axis_uart_pkg::axis_beat_t exp;
        int unsigned               n;
        exp.tdata = data;
        n = 0;
        while (!rx_valid && n < BEAT_TIMEOUT) begin
            @(negedge m_axis);
            n++;
        end
        if (!rx_valid) begin
            report_failure("no beat came out of the receiver after a frame was sent");
        end else begin
            check_beat("rx_beat_o", rx_beat, exp);
        end
    endtask

    task automatic loopback_bytes(input int unsigned count);
        logic [7:0] data;
        for (int unsigned i = 0; i < count; i++) begin
            next_byte(data);
            send_beat(data);
            expect_beat(data);
            wait_tx_idle();
        end
    endtask

    task automatic drive_bit(input logic b);
        bang_line = b;
        repeat (TEST_DIVIDER) @(negedge m_axis);
    endtask

    task automatic bang_frame(input logic [7:0] data, input logic bad_parity,
                              input logic bad_stop);
        @(negedge m_axis);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (cur_parity != axis_uart_pkg::PARITY_NONE) begin
            drive_bit(frame_parity_bit(data, cur_parity) ^ bad_parity);
        end
        drive_bit(!bad_stop);
        bang_line = 1'b1;
        repeat (2 * TEST_DIVIDER) @(negedge m_axis);
    endtask

    task automatic set_parity(input axis_uart_pkg::uart_parity_e mode);
        cmd(axis_uart_pkg::OP_SET_PARITY, 16'(mode));
        cur_parity = mode;
    endtask

    task automatic test_config();
        check_bit("tx_ready_o", tx_ready, 1'b1);
        check_bit("uart_tx_o", uart_tx, 1'b1);
        check_bit("rx_valid_o", rx_valid, 1'b0);
        check_bit("cfg_ack_o", cfg_ack, 1'b0);
        expect_status(8'd0, 1'b0, 1'b0);
        cmd(axis_uart_pkg::OP_SET_DIVIDER, 16'(TEST_DIVIDER));
        set_parity(axis_uart_pkg::PARITY_EVEN);
    endtask

    task automatic test_plain_loopback();
        logic [7:0]                  data;
        axis_uart_pkg::uart_status_t exp;
        set_parity(axis_uart_pkg::PARITY_NONE);
        loopback_bytes(8);
        // one bit period into the frame both data paths are busy
        next_byte(data);
        send_beat(data);
        repeat (TEST_DIVIDER) @(negedge m_axis);
        exp         = status_of(8'd0, 1'b0, 1'b0);
        exp.tx_busy = 1'b1;
        exp.rx_busy = 1'b1;
        cmd(axis_uart_pkg::OP_READ_STATUS, 16'h0000);
        check_status("cfg_rdata_o", last_status, exp);
        expect_beat(data);
        wait_tx_idle();
    endtask

    task automatic test_parity_loopback();
        set_parity(axis_uart_pkg::PARITY_EVEN);
        loopback_bytes(8);
        set_parity(axis_uart_pkg::PARITY_ODD);
        loopback_bytes(8);
        expect_status(8'd0, 1'b0, 1'b0);
    endtask

    task automatic test_injected_errors();
        logic [7:0]  data;
        int unsigned seen;
        loopback = 1'b0;
        next_byte(data);
        seen = beat_count;
        bang_frame(data, 1'b1, 1'b0);
        if (beat_count != seen) begin
            report_failure("a frame with a bad parity bit produced a beat");
        end
        expect_status(8'd1, 1'b0, 1'b0);
        next_byte(data);
        seen = beat_count;
        bang_frame(data, 1'b0, 1'b1);
        if (beat_count != seen) begin
            report_failure("a frame with a low stop bit produced a beat");
        end
        expect_status(8'd1, 1'b1, 1'b0);
        loopback = 1'b1;
    endtask

    task automatic test_overrun();
        logic [7:0]                first;
        logic [7:0]                second;
        axis_uart_pkg::axis_beat_t exp;
        int unsigned               seen;
        next_byte(first);
        next_byte(second);
        if (second == first) begin
            second = ~first;
        end
        exp.tdata = first;
        @(negedge m_axis);
        rx_ready = 1'b0;
        send_beat(first);
        wait_tx_idle();
        send_beat(second);
        wait_tx_idle();
        check_bit("rx_valid_o", rx_valid, 1'b1);
        check_beat("rx_beat_o", rx_beat, exp);
        expect_status(8'd1, 1'b1, 1'b1);
        seen = beat_count;
        @(negedge m_axis);
        rx_ready = 1'b1;
        @(negedge m_axis);
        check_bit("rx_valid_o", rx_valid, 1'b0);
        repeat (FRAME_CLKS) @(negedge m_axis);
        if (beat_count != seen) begin
            report_failure("the byte dropped by the overrun still came out");
        end
    endtask

    task automatic test_clear();
        cmd(axis_uart_pkg::OP_CLEAR_STATUS, 16'h0000);
        expect_status(8'd0, 1'b0, 1'b0);
    endtask

    initial begin
        rst_n         = 1'b0;
        cfg_req       = 1'b0;
        cfg_cmd       = '0;
        rx_ready      = 1'b1;
        tx_valid      = 1'b0;
        tx_beat       = '0;
        loopback      = 1'b1;
        bang_line     = 1'b1;
        rx_valid_prev = 1'b0;
        error_count   = 0;
        check_count   = 0;
        beat_count    = 0;
        rng_state     = 32'h22105d11;
        last_status   = '0;
        cur_parity    = axis_uart_pkg::PARITY_NONE;
        repeat (4) @(negedge m_axis);
        rst_n = 1'b1;

        test_config();
        test_plain_loopback();
        test_parity_loopback();
        test_injected_errors();
        test_overrun();
        test_clear();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog/axis_uart.sv
`timescale 1ns/1ns

module axis_uart (
    input  logic                        m_axis,
    input  logic                        rst_n_i,

    input  logic                        cfg_req_i,
    input  axis_uart_pkg::csr_req_t     cfg_cmd_i,
    output logic                        cfg_ack_o,
    output axis_uart_pkg::uart_status_t cfg_rdata_o,

    input  logic                        uart_rx_i,
    output logic                        uart_tx_o,

    output logic                        rx_valid_o,
    output axis_uart_pkg::axis_beat_t   rx_beat_o,
    input  logic                        rx_ready_i,

    input  logic                        tx_valid_i,
    input  axis_uart_pkg::axis_beat_t   tx_beat_i,
    output logic                        tx_ready_o
);

    axis_uart_pkg::uart_cfg_t  cfg;
    axis_uart_pkg::rx_event_t  rx_evt;
    logic                      rx_busy;
    logic                      tx_busy;

    axis_uart_csr u_csr (
        .m_axis      (m_axis),
        .rst_n_i     (rst_n_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_cmd_i   (cfg_cmd_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (cfg),
        .rx_evt_i    (rx_evt),
        .rx_busy_i   (rx_busy),
        .tx_busy_i   (tx_busy)
    );

    axis_uart_rx u_rx (
        .m_axis     (m_axis),
        .rst_n_i    (rst_n_i),
        .cfg_i      (cfg),
        .uart_rx_i  (uart_rx_i),
        .rx_valid_o (rx_valid_o),
        .rx_beat_o  (rx_beat_o),
        .rx_ready_i (rx_ready_i),
        .rx_evt_o   (rx_evt),
        .rx_busy_o  (rx_busy)
    );

    axis_uart_tx u_tx (
        .m_axis     (m_axis),
        .rst_n_i    (rst_n_i),
        .cfg_i      (cfg),
        .tx_valid_i (tx_valid_i),
        .tx_beat_i  (tx_beat_i),
        .tx_ready_o (tx_ready_o),
        .uart_tx_o  (uart_tx_o),
        .tx_busy_o  (tx_busy)
    );

endmodule

//--- verilog/axis_uart_csr.sv
`timescale 1ns/1ns
`include "axis_uart_macros.svh"

module axis_uart_csr (
    input  logic                        m_axis,
    input  logic                        rst_n_i,
    input  logic                        cfg_req_i,
    input  axis_uart_pkg::csr_req_t     cfg_cmd_i,
    output logic                        cfg_ack_o,
    output axis_uart_pkg::uart_status_t cfg_rdata_o,
    output axis_uart_pkg::uart_cfg_t    cfg_o,
    input  axis_uart_pkg::rx_event_t    rx_evt_i,
    input  logic                        rx_busy_i,
    input  logic                        tx_busy_i
);

    localparam logic [`AXIS_UART_DIVIDER_WIDTH-1:0] MIN_DIVIDER =
        `AXIS_UART_DIVIDER_WIDTH'(4);

    logic [1:0]                  req_sync;
    logic                        execute;
    logic [7:0]                  parity_err_cnt;
    logic                        frame_err;
    logic                        overrun;
    logic                        clear;
    axis_uart_pkg::uart_status_t status;

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_sync <= 2'b00;
        end else begin
            req_sync <= {req_sync[0], cfg_req_i};
        end
    end

    // each command runs once, on the rising edge of the synchronized req
    assign execute = req_sync[1] && !cfg_ack_o;
    assign clear   = execute && (cfg_cmd_i.op == axis_uart_pkg::OP_CLEAR_STATUS);

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_ack_o   <= 1'b0;
            cfg_rdata_o <= '0;
            cfg_o       <= '{divider: `AXIS_UART_DIVIDER_WIDTH'(`AXIS_UART_RESET_DIVIDER),
                             parity:  axis_uart_pkg::PARITY_NONE};
        end else begin
            cfg_ack_o <= req_sync[1];
            if (execute) begin
                case (cfg_cmd_i.op)
                    axis_uart_pkg::OP_SET_DIVIDER: begin
                        cfg_o.divider <= (cfg_cmd_i.arg < MIN_DIVIDER) ? MIN_DIVIDER
                                                                       : cfg_cmd_i.arg;
                    end
                    axis_uart_pkg::OP_SET_PARITY: begin
                        if (cfg_cmd_i.arg > 2) begin
                            cfg_o.parity <= axis_uart_pkg::PARITY_NONE;
                        end else begin
                            cfg_o.parity <= axis_uart_pkg::uart_parity_e'(cfg_cmd_i.arg[1:0]);
                        end
                    end
                    axis_uart_pkg::OP_READ_STATUS: begin
                        cfg_rdata_o <= status;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // an event in the same clock as a clear still gets recorded
    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            parity_err_cnt <= '0;
            frame_err      <= 1'b0;
            overrun        <= 1'b0;
        end else begin
            if (clear) begin
                parity_err_cnt <= '0;
                frame_err      <= 1'b0;
                overrun        <= 1'b0;
            end
            if (rx_evt_i.parity_err && (clear || (parity_err_cnt != 8'hff))) begin
                parity_err_cnt <= clear ? 8'd1 : parity_err_cnt + 8'd1;
            end
            if (rx_evt_i.frame_err) begin
                frame_err <= 1'b1;
            end
            if (rx_evt_i.overrun) begin
                overrun <= 1'b1;
            end
        end
    end

    always_comb begin
        status                = '0;
        status.parity_err_cnt = parity_err_cnt;
        status.frame_err      = frame_err;
        status.overrun        = overrun;
        status.tx_busy        = tx_busy_i;
        status.rx_busy        = rx_busy_i;
    end

endmodule

//--- verilog/axis_uart_tx.sv
`timescale 1ns/1ns
`include "axis_uart_macros.svh"

module axis_uart_tx (
    input  logic                      m_axis,
    input  logic                      rst_n_i,
    input  axis_uart_pkg::uart_cfg_t  cfg_i,
    input  logic                      tx_valid_i,
    input  axis_uart_pkg::axis_beat_t tx_beat_i,
    output logic                      tx_ready_o,
    output logic                      uart_tx_o,
    output logic                      tx_busy_o
);

    localparam int unsigned BIT_CNT_W = $clog2(`AXIS_UART_DATA_WIDTH);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`AXIS_UART_DATA_WIDTH - 1);

    axis_uart_pkg::tx_state_e state;
    axis_uart_pkg::uart_cfg_t cfg_q;

    logic [`AXIS_UART_DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]                bit_cnt;
    logic [`AXIS_UART_DATA_WIDTH-1:0]    data_q;
    logic                                par_q;
    logic                                accept;
    logic                                bit_tick;
    logic                                stop_tick;
    logic                                line_d;

    assign tx_ready_o = (state == axis_uart_pkg::TX_IDLE);
    assign tx_busy_o  = !tx_ready_o;
    assign accept     = tx_valid_i && tx_ready_o;
    assign bit_tick   = (baud_cnt == cfg_q.divider - 1'b1);
    // the line lags the state by one clock, so the stop state runs one clock longer
    assign stop_tick  = (baud_cnt == cfg_q.divider);

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= axis_uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                axis_uart_pkg::TX_IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (accept) begin
                        state <= axis_uart_pkg::TX_START;
                    end
                end
                axis_uart_pkg::TX_START: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        state    <= axis_uart_pkg::TX_DATA;
                    end
                end
                axis_uart_pkg::TX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            if (cfg_q.parity == axis_uart_pkg::PARITY_NONE) begin
                                state <= axis_uart_pkg::TX_STOP;
                            end else begin
                                state <= axis_uart_pkg::TX_PARITY;
                            end
                        end
                    end
                end
                axis_uart_pkg::TX_PARITY: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        state    <= axis_uart_pkg::TX_STOP;
                    end
                end
                axis_uart_pkg::TX_STOP: begin
                    if (stop_tick) begin
                        state <= axis_uart_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= axis_uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // byte, parity bit and config are frozen for the whole frame
    always_ff @(posedge m_axis) begin
        if (accept) begin
            data_q <= tx_beat_i.tdata;
            par_q  <= axis_uart_pkg::parity_of(tx_beat_i.tdata, cfg_i.parity);
            cfg_q  <= cfg_i;
        end else if ((state == axis_uart_pkg::TX_DATA) && bit_tick) begin
            data_q <= data_q >> 1;
        end
    end

    always_comb begin
        case (state)
            axis_uart_pkg::TX_START:  line_d = 1'b0;
            axis_uart_pkg::TX_DATA:   line_d = data_q[0];
            axis_uart_pkg::TX_PARITY: line_d = par_q;
            default:                  line_d = 1'b1;
        endcase
    end

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            uart_tx_o <= 1'b1;
        end else begin
            uart_tx_o <= line_d;
        end
    end

endmodule

//--- verilog/axis_uart_rx.sv
`timescale 1ns/1ns
`include "axis_uart_macros.svh"

module axis_uart_rx (
    input  logic                     m_axis,
    input  logic                     rst_n_i,
    input  axis_uart_pkg::uart_cfg_t cfg_i,
    input  logic                     uart_rx_i,
    output logic                     rx_valid_o,
    output axis_uart_pkg::axis_beat_t rx_beat_o,
    input  logic                     rx_ready_i,
    output axis_uart_pkg::rx_event_t rx_evt_o,
    output logic                     rx_busy_o
);

    localparam int unsigned BIT_CNT_W = $clog2(`AXIS_UART_DATA_WIDTH);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`AXIS_UART_DATA_WIDTH - 1);

    axis_uart_pkg::rx_state_e state;
    axis_uart_pkg::uart_cfg_t cfg_q;

    logic [1:0]                          rx_sync;
    logic                                rx_line;
    logic [`AXIS_UART_DIVIDER_WIDTH-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]                bit_cnt;
    logic [`AXIS_UART_DATA_WIDTH-1:0]    shreg;
    logic                                parity_bad;
    logic                                stop_ok;
    logic                                bit_tick;
    logic                                half_tick;
    logic                                frame_good;
    logic                                load_beat;

    // the serial line is asynchronous to m_axis
    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
        end
    end

    assign rx_line   = rx_sync[1];
    assign bit_tick  = (baud_cnt == cfg_q.divider - 1'b1);
    assign half_tick = (baud_cnt == (cfg_q.divider >> 1) - 1'b1);

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= axis_uart_pkg::RX_IDLE;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            parity_bad <= 1'b0;
            stop_ok    <= 1'b0;
        end else begin
            case (state)
                axis_uart_pkg::RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_line) begin
                        state <= axis_uart_pkg::RX_START;
                    end
                end
                axis_uart_pkg::RX_START: begin
                    if (half_tick) begin
                        baud_cnt   <= '0;
                        bit_cnt    <= '0;
                        parity_bad <= 1'b0;
                        // a glitch shorter than half a bit is not a start bit
                        state      <= rx_line ? axis_uart_pkg::RX_IDLE : axis_uart_pkg::RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                axis_uart_pkg::RX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            if (cfg_q.parity == axis_uart_pkg::PARITY_NONE) begin
                                state <= axis_uart_pkg::RX_STOP;
                            end else begin
                                state <= axis_uart_pkg::RX_PARITY;
                            end
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                axis_uart_pkg::RX_PARITY: begin
                    if (bit_tick) begin
                        baud_cnt   <= '0;
                        parity_bad <= (rx_line != axis_uart_pkg::parity_of(shreg, cfg_q.parity));
                        state      <= axis_uart_pkg::RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                axis_uart_pkg::RX_STOP: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        stop_ok  <= rx_line;
                        state    <= axis_uart_pkg::RX_WAIT;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= axis_uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // config is taken once per frame, on the way out of idle
    always_ff @(posedge m_axis) begin
        if ((state == axis_uart_pkg::RX_IDLE) && !rx_line) begin
            cfg_q <= cfg_i;
        end
        if ((state == axis_uart_pkg::RX_DATA) && bit_tick) begin
            shreg <= {rx_line, shreg[`AXIS_UART_DATA_WIDTH-1:1]};
        end
    end

    assign frame_good = !parity_bad && stop_ok;
    assign load_beat  = (state == axis_uart_pkg::RX_WAIT) && frame_good &&
                        (!rx_valid_o || rx_ready_i);

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_valid_o <= 1'b0;
        end else if (load_beat) begin
            rx_valid_o <= 1'b1;
        end else if (rx_ready_i) begin
            rx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge m_axis) begin
        if (load_beat) begin
            rx_beat_o.tdata <= shreg;
        end
    end

    always_ff @(posedge m_axis or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_evt_o <= '0;
        end else begin
            rx_evt_o <= '0;
            if (state == axis_uart_pkg::RX_WAIT) begin
                rx_evt_o.parity_err <= parity_bad;
                rx_evt_o.frame_err  <= !stop_ok;
                // the held beat wins, the new byte is lost
                rx_evt_o.overrun    <= frame_good && rx_valid_o && !rx_ready_i;
            end
        end
    end

    assign rx_busy_o = (state != axis_uart_pkg::RX_IDLE);

endmodule

//--- verilog/axis_uart_pkg.sv
`include "axis_uart_macros.svh"

package axis_uart_pkg;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } uart_parity_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_WAIT
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        OP_SET_DIVIDER  = 2'd0,
        OP_SET_PARITY   = 2'd1,
        OP_READ_STATUS  = 2'd2,
        OP_CLEAR_STATUS = 2'd3
    } csr_op_e;

    typedef struct packed {
        csr_op_e                             op;
        logic [`AXIS_UART_DIVIDER_WIDTH-1:0] arg;
    } csr_req_t;

    typedef struct packed {
        logic [`AXIS_UART_DIVIDER_WIDTH-1:0] divider;
        uart_parity_e                        parity;
    } uart_cfg_t;

    typedef struct packed {
        logic [`AXIS_UART_DATA_WIDTH-1:0] tdata;
    } axis_beat_t;

    // one-cycle pulses from the receiver
    typedef struct packed {
        logic parity_err;
        logic frame_err;
        logic overrun;
    } rx_event_t;

    typedef struct packed {
        logic [7:0] parity_err_cnt;
        logic       frame_err;
        logic       overrun;
        logic       tx_busy;
        logic       rx_busy;
        logic [3:0] reserved;
    } uart_status_t;

    // even parity makes the total count of ones even, odd makes it odd
    function automatic logic parity_of(input logic [`AXIS_UART_DATA_WIDTH-1:0] data,
                                       input uart_parity_e mode);
        case (mode)
            PARITY_EVEN: return ^data;
            PARITY_ODD:  return ~^data;
            default:     return 1'b0;
        endcase
    endfunction

endpackage

//--- verilog/axis_uart_macros.svh
`ifndef AXIS_UART_MACROS_SVH
`define AXIS_UART_MACROS_SVH

// data bits carried in one serial frame and in one stream beat
`define AXIS_UART_DATA_WIDTH 8

// width of the runtime baud divider, in bits
`define AXIS_UART_DIVIDER_WIDTH 16

// clocks per bit right after reset
`define AXIS_UART_RESET_DIVIDER 16

`endif
